/* bench/eth_bridge_props.sv */
/* ethernet bridge protocol checker
   bound to the top level, watches downlink size, mac tx strobes and uplink */
`timescale 1ns/10ps
`default_nettype none

module eth_bridge_props (
    input logic                       clk125M,
    input logic                       rst_n_i,
    input logic                       lnk_rx_valid_i,
    input logic                       lnk_rx_last_i,
    input logic                       lnk_tx_valid_o,
    input logic                       lnk_tx_last_o,
    input logic                       module_en_i,
    input logic                       link_up_i,
    input eth_bridge_pkg::port_mask_t mac_link_i,
    input eth_bridge_pkg::port_mask_t mac_tx_rq_o,
    input eth_bridge_pkg::port_mask_t mac_tx_valid_o,
    input eth_bridge_pkg::port_mask_t mac_tx_sof_o,
    input eth_bridge_pkg::port_mask_t mac_tx_eof_o
);
    import eth_bridge_pkg::*;

    buf_cnt_t   dl_cnt_q;            // bytes of the open downlink frame
    port_mask_t port_en;
    logic       bad_dl     = 1'b0;   // one sticky flag per property
    logic       bad_contig = 1'b0;
    logic       bad_rq     = 1'b0;
    logic       bad_strobe = 1'b0;
    logic       prop_fail;           // read by the testbench

    assign port_en   = mac_link_i & {ETH_COUNT{module_en_i & link_up_i}};
    assign prop_fail = bad_dl | bad_contig | bad_rq | bad_strobe;

    // saturates at the buffer size, enough to see an overlong frame
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dl_cnt_q <= '0;
        end else if (lnk_rx_valid_i) begin
            if (lnk_rx_last_i) begin
                dl_cnt_q <= '0;
            end else if (dl_cnt_q != buf_cnt_t'(TX_BUF_DEPTH)) begin
                dl_cnt_q <= dl_cnt_q + buf_cnt_t'(1);
            end
        end
    end

    //----------------------------------------------------------------------
    // properties
    //----------------------------------------------------------------------
    a_dl_fits : assert property (@(posedge clk125M) disable iff (!rst_n_i)
        lnk_rx_valid_i |-> dl_cnt_q < buf_cnt_t'(TX_BUF_DEPTH))
        else begin
            $error("downlink frame longer than the tx buffer");
            bad_dl = 1'b1;
        end

    // a byte without eof must be followed by another byte
    a_tx_contig : assert property (@(posedge clk125M) disable iff (!rst_n_i)
        ($past(mac_tx_valid_o & ~mac_tx_eof_o) & ~mac_tx_valid_o) == '0)
        else begin
            $error("mac tx valid gap inside a frame");
            bad_contig = 1'b1;
        end

    a_rq_hold : assert property (@(posedge clk125M) disable iff (!rst_n_i)
        ($past(mac_tx_rq_o & port_en & ~(mac_tx_valid_o & mac_tx_eof_o))
         & ~mac_tx_rq_o) == '0)
        else begin
            $error("mac tx request dropped before eof");
            bad_rq = 1'b1;
        end

    a_strobes : assert property (@(posedge clk125M) disable iff (!rst_n_i)
        ((mac_tx_sof_o & ~mac_tx_valid_o) == '0) && !(lnk_tx_last_o && !lnk_tx_valid_o))
        else begin
            $error("frame strobe without valid");
            bad_strobe = 1'b1;
        end

endmodule

bind eth_bridge eth_bridge_props i_props (
    .clk125M        (clk125M),
    .rst_n_i        (rst_n_i),
    .lnk_rx_valid_i (lnk_rx_valid_i),
    .lnk_rx_last_i  (lnk_rx_last_i),
    .lnk_tx_valid_o (lnk_tx_valid_o),
    .lnk_tx_last_o  (lnk_tx_last_o),
    .module_en_i    (module_en_i),
    .link_up_i      (link_up_i),
    .mac_link_i     (mac_link_i),
    .mac_tx_rq_o    (mac_tx_rq_o),
    .mac_tx_valid_o (mac_tx_valid_o),
    .mac_tx_sof_o   (mac_tx_sof_o),
    .mac_tx_eof_o   (mac_tx_eof_o)
);

`default_nettype wire

/* bench/tb_eth_bridge.sv */
/* ethernet bridge testbench
   downlink to mac, ack wait, header strip, port gating and uplink selection */
`timescale 1ns/10ps
`default_nettype none

module tb_eth_bridge;
    import eth_bridge_pkg::*;

    localparam int DL_LEN    = 20;   // downlink frame bytes
    localparam int ACK_MAX   = 30;   // longest withheld ack
    localparam int DL_FRAMES = 9;    // 4 direct, 2 delayed ack, 3 gated
    localparam int RX_LEN    = 30;
    localparam int RX_MAX    = 40;   // longest mac rx frame
    localparam int RX_FRAMES = 9;    // strip 3, gated 3, selection 3
    // every frame at its worst case, doubled
    localparam int CYCLE_LIMIT = 2 * (DL_FRAMES * (2 * DL_LEN + ACK_MAX + 12)
                                      + RX_FRAMES * (RX_MAX + 6) + 8);

    logic                  clk125M;
    logic                  rst_n_i;
    byte_t                 lnk_rx_data_i;
    logic                  lnk_rx_valid_i;
    logic                  lnk_rx_last_i;
    byte_t                 lnk_tx_data_o;
    logic                  lnk_tx_valid_o;
    logic                  lnk_tx_last_o;
    port_idx_t             eth_num_i;
    logic                  module_en_i;
    logic                  link_up_i;
    port_mask_t            mac_link_i;
    port_mask_t            mac_tx_ack_i;
    byte_t [ETH_COUNT-1:0] mac_rx_data_i;
    port_mask_t            mac_rx_den_i;
    port_mask_t            mac_rx_sof_i;
    port_mask_t            mac_rx_eof_i;
    port_mask_t            mac_tx_rq_o;
    byte_t [ETH_COUNT-1:0] mac_tx_data_o;
    port_mask_t            mac_tx_valid_o;
    port_mask_t            mac_tx_sof_o;
    port_mask_t            mac_tx_eof_o;

    integer seed;
    int     cycle_cnt = 0;
    byte_t  dl_data [DL_LEN];             // last downlink frame sent
    byte_t  rx_data [ETH_COUNT][RX_MAX];  // last mac rx frame per port

    eth_bridge i_eth_bridge (.*);

    initial begin
        clk125M = 1'b0;
        forever #4 clk125M = ~clk125M;  // 125 MHz
    end

    // watchdog, also picks up the bound checker
    always @(posedge clk125M) begin
        cycle_cnt <= cycle_cnt + 1;
        if (i_eth_bridge.i_props.prop_fail) begin
            report_failure("a bound protocol assertion fired");
        end else if (cycle_cnt >= CYCLE_LIMIT) begin
            report_failure("timeout, the run took too many cycles");
        end
    end

    //----------------------------------------------------------------------
    // reporting
    //----------------------------------------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic port_mask_t others_mask(input int port);
        return ~(port_mask_t'(1) << port);
    endfunction

    //----------------------------------------------------------------------
    // stimulus and response helpers
    //----------------------------------------------------------------------
    // random frame on the serial downlink, target picked by eth_num_i
    task automatic send_dl_frame(input int port);
        int i;
        for (i = 0; i < DL_LEN; i++) begin
            dl_data[i] = byte_t'($random(seed));
        end
        for (i = 0; i < DL_LEN; i++) begin
            @(posedge clk125M);
            #1;
            eth_num_i      = port_idx_t'(port);
            lnk_rx_data_i  = dl_data[i];
            lnk_rx_valid_i = 1'b1;
            lnk_rx_last_i  = (i == DL_LEN - 1);
        end
        @(posedge clk125M);
        #1;
        lnk_rx_valid_i = 1'b0;
        lnk_rx_last_i  = 1'b0;
    endtask

    // waits for the frame on the mac, checks bytes, strobes, request
    task automatic check_tx_frame(input int port);
        int i;
        bit rq_seen;
        rq_seen = 1'b0;
        @(negedge clk125M);
        while (!mac_tx_valid_o[port]) begin
            if (mac_tx_rq_o[port]) begin
                rq_seen = 1'b1;
            end
            @(negedge clk125M);
        end
        assert (rq_seen) else report_failure("mac tx data started without a request");
        for (i = 0; i < DL_LEN; i++) begin
            if (i > 0) begin
                @(negedge clk125M);
            end
            assert (mac_tx_valid_o[port])
                else report_mismatch("mac_tx_valid_o", 32'(mac_tx_valid_o), 32'(1 << port));
            assert (mac_tx_data_o[port] == dl_data[i])
                else report_mismatch($sformatf("mac_tx_data_o[%0d]", port),
                                     32'(mac_tx_data_o[port]), 32'(dl_data[i]));
            assert (mac_tx_sof_o[port] == (i == 0))
                else report_mismatch("mac_tx_sof_o", 32'(mac_tx_sof_o[port]), 32'(i == 0));
            assert (mac_tx_eof_o[port] == (i == DL_LEN - 1))
                else report_mismatch("mac_tx_eof_o", 32'(mac_tx_eof_o[port]),
                                     32'(i == DL_LEN - 1));
            assert ((mac_tx_rq_o & others_mask(port)) == '0)
                else report_mismatch("mac_tx_rq_o", 32'(mac_tx_rq_o), 32'(1 << port));
        end
        @(negedge clk125M);  // request falls after eof
        assert (!mac_tx_rq_o[port])
            else report_mismatch("mac_tx_rq_o", 32'(mac_tx_rq_o), 32'(0));
    endtask

    // mac rx frames on the ports in the mask, uplink checked per cycle.
    // fwd < 0 means no uplink output at all
    task automatic run_rx(input port_mask_t ports, input int len, input int fwd,
                          input int sw_at, input int sw_to);
        int n;
        int m;
        int p;
        bit exp_valid;
        for (p = 0; p < ETH_COUNT; p++) begin
            for (n = 0; n < len; n++) begin
                rx_data[p][n] = byte_t'($random(seed));
            end
        end
        for (n = 0; n < len + 4; n++) begin
            @(posedge clk125M);
            #1;
            if (n == sw_at) begin
                eth_num_i = port_idx_t'(sw_to);  // mid-frame selection change
            end
            for (p = 0; p < ETH_COUNT; p++) begin
                if (n < len) begin
                    mac_rx_data_i[p] = rx_data[p][n];
                end else begin
                    mac_rx_data_i[p] = '0;
                end
                mac_rx_den_i[p] = ports[p] && (n < len);
                mac_rx_sof_i[p] = ports[p] && (n == 0);
                mac_rx_eof_i[p] = ports[p] && (n == len - 1);
            end
            @(negedge clk125M);
            m = n - 2;  // input byte now due on the uplink
            exp_valid = (fwd >= 0) && (m >= RX_HDR_BYTES) && (m < len);
            assert (lnk_tx_valid_o == exp_valid)
                else report_mismatch("lnk_tx_valid_o", 32'(lnk_tx_valid_o), 32'(exp_valid));
            if (exp_valid) begin
                assert (lnk_tx_data_o == rx_data[fwd][m])
                    else report_mismatch("lnk_tx_data_o", 32'(lnk_tx_data_o),
                                         32'(rx_data[fwd][m]));
                assert (lnk_tx_last_o == (m == len - 1))
                    else report_mismatch("lnk_tx_last_o", 32'(lnk_tx_last_o),
                                         32'(m == len - 1));
            end
        end
    endtask

    //----------------------------------------------------------------------
    // tests
    //----------------------------------------------------------------------
    task automatic dl_to_mac_test();
        int k;
        for (k = 0; k < ETH_COUNT; k++) begin
            @(posedge clk125M);
            #1;
            mac_tx_ack_i = port_mask_t'(1) << k;  // ack already up
            send_dl_frame(k);
            check_tx_frame(k);
        end
        @(posedge clk125M);
        #1;
        mac_tx_ack_i = '0;
    endtask

    task automatic ack_delay_test();
        int j;
        int k;
        int d;
        int n;
        for (j = 0; j < 2; j++) begin
            k = (j == 0) ? 3 : 0;
            d = 5 + ($unsigned($random(seed)) % 26);
            send_dl_frame(k);
            @(negedge clk125M);
            while (!mac_tx_rq_o[k]) begin
                @(negedge clk125M);
            end
            for (n = 0; n < d; n++) begin  // mac keeps us waiting
                @(negedge clk125M);
                assert (mac_tx_rq_o[k])
                    else report_mismatch("mac_tx_rq_o", 32'(mac_tx_rq_o), 32'(1 << k));
                assert (mac_tx_valid_o == '0)
                    else report_mismatch("mac_tx_valid_o", 32'(mac_tx_valid_o), 32'(0));
            end
            @(posedge clk125M);
            #1;
            mac_tx_ack_i[k] = 1'b1;
            check_tx_frame(k);
            @(posedge clk125M);
            #1;
            mac_tx_ack_i = '0;
        end
    endtask

    task automatic header_strip_test();
        @(posedge clk125M);
        #1;
        eth_num_i = 2'd2;
        run_rx(port_mask_t'(4), RX_MAX, 2, -1, 0);
        run_rx(port_mask_t'(4), RX_HDR_BYTES + 1, 2, -1, 0);  // one byte kept
        run_rx(port_mask_t'(4), 10, -1, -1, 0);               // header only
    endtask

    task automatic gating_test();
        int cond;
        int n;
        for (cond = 0; cond < 3; cond++) begin
            @(posedge clk125M);
            #1;
            case (cond)
                0: module_en_i = 1'b0;
                1: link_up_i = 1'b0;
                default: mac_link_i[1] = 1'b0;
            endcase
            send_dl_frame(1);
            for (n = 0; n < 30; n++) begin
                @(negedge clk125M);
                assert (mac_tx_rq_o == '0)
                    else report_mismatch("mac_tx_rq_o", 32'(mac_tx_rq_o), 32'(0));
            end
            run_rx(port_mask_t'(2), RX_LEN, -1, -1, 0);
            @(posedge clk125M);
            #1;
            module_en_i = 1'b1;
            link_up_i   = 1'b1;
            mac_link_i  = '1;
            repeat (4) @(negedge clk125M);
            assert (mac_tx_rq_o == '0)  // nothing left over in the buffer
                else report_mismatch("mac_tx_rq_o", 32'(mac_tx_rq_o), 32'(0));
        end
    endtask

    task automatic selection_test();
        @(posedge clk125M);
        #1;
        eth_num_i = 2'd0;
        run_rx(port_mask_t'(1), RX_LEN, 0, 20, 1);    // switch to 1 after byte 20
        run_rx(port_mask_t'(3), RX_LEN, 1, -1, 0);    // ports 0 and 1 at once
        @(posedge clk125M);
        #1;
        eth_num_i = 2'd2;
        run_rx(port_mask_t'(12), RX_LEN, 2, -1, 0);   // ports 2 and 3 at once
    endtask

    //----------------------------------------------------------------------
    // main sequence
    //----------------------------------------------------------------------
    initial begin
        seed           = 32'h1822_bb8e;
        rst_n_i        = 1'b0;
        lnk_rx_data_i  = '0;
        lnk_rx_valid_i = 1'b0;
        lnk_rx_last_i  = 1'b0;
        eth_num_i      = '0;
        module_en_i    = 1'b1;
        link_up_i      = 1'b1;
        mac_link_i     = '1;
        mac_tx_ack_i   = '0;
        mac_rx_data_i  = '0;
        mac_rx_den_i   = '0;
        mac_rx_sof_i   = '0;
        mac_rx_eof_i   = '0;
        repeat (3) @(posedge clk125M);
        #1;
        rst_n_i = 1'b1;

        dl_to_mac_test();
        ack_delay_test();
        header_strip_test();
        gating_test();
        selection_test();

        @(negedge clk125M);  // checker has seen the last edge by now
        if (i_eth_bridge.i_props.prop_fail) begin
            report_failure("a bound protocol assertion fired");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* eth_bridge.f */
source/eth_bridge_pkg.sv
source/port_bus_if.sv
source/port_dispatch.sv
source/eth_port.sv
source/port_collect.sv
source/eth_bridge.sv
bench/eth_bridge_props.sv
bench/tb_eth_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build the ethernet bridge testbench with Verilator and run it.
# The exit status is the simulator's: non-zero when the testbench fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f eth_bridge.f \
    --top-module tb_eth_bridge \
    -Mdir obj_dir \
    -o tb_eth_bridge
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build returned status $status"
    exit $status
fi

# keep running past a bound assertion so the testbench reports it itself
./obj_dir/tb_eth_bridge +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit $status
fi
exit 0

/* source/eth_bridge.sv */
/* ethernet bridge top
   downlink dispatcher, ETH_COUNT port bridges and the uplink collector */
`timescale 1ns/10ps
`default_nettype none

module eth_bridge (
    input  logic                       clk125M,
    input  logic                       rst_n_i,
    // serial link downlink
    input  eth_bridge_pkg::byte_t      lnk_rx_data_i,
    input  logic                       lnk_rx_valid_i,
    input  logic                       lnk_rx_last_i,
    // serial link uplink
    output eth_bridge_pkg::byte_t      lnk_tx_data_o,
    output logic                       lnk_tx_valid_o,
    output logic                       lnk_tx_last_o,
    // control
    input  eth_bridge_pkg::port_idx_t  eth_num_i,
    input  logic                       module_en_i,
    input  logic                       link_up_i,     // serial channel up
    // from the macs, one lane per port
    input  eth_bridge_pkg::port_mask_t mac_link_i,
    input  eth_bridge_pkg::port_mask_t mac_tx_ack_i,
    input  eth_bridge_pkg::byte_t [eth_bridge_pkg::ETH_COUNT-1:0] mac_rx_data_i,
    input  eth_bridge_pkg::port_mask_t mac_rx_den_i,
    input  eth_bridge_pkg::port_mask_t mac_rx_sof_i,
    input  eth_bridge_pkg::port_mask_t mac_rx_eof_i,
    // to the macs
    output eth_bridge_pkg::port_mask_t mac_tx_rq_o,
    output eth_bridge_pkg::byte_t [eth_bridge_pkg::ETH_COUNT-1:0] mac_tx_data_o,
    output eth_bridge_pkg::port_mask_t mac_tx_valid_o,
    output eth_bridge_pkg::port_mask_t mac_tx_sof_o,
    output eth_bridge_pkg::port_mask_t mac_tx_eof_o
);
    import eth_bridge_pkg::*;

    port_bus_if dn_bus [ETH_COUNT] ();  // dispatcher -> ports
    port_bus_if up_bus [ETH_COUNT] ();  // ports -> collector
    port_mask_t port_en;

    // same condition that held the port fifos in reset on the board
    assign port_en = mac_link_i & {ETH_COUNT{module_en_i & link_up_i}};

    port_dispatch i_dispatch (
        .clk125M   (clk125M),
        .rst_n_i   (rst_n_i),
        .data_i    (lnk_rx_data_i),
        .valid_i   (lnk_rx_valid_i),
        .last_i    (lnk_rx_last_i),
        .eth_num_i (eth_num_i),
        .dn        (dn_bus)
    );

    for (genvar g = 0; g < ETH_COUNT; g++) begin : g_eth
        eth_port i_port (
            .clk125M        (clk125M),
            .rst_n_i        (rst_n_i),
            .port_en_i      (port_en[g]),
            .dn             (dn_bus[g]),
            .up             (up_bus[g]),
            .mac_tx_ack_i   (mac_tx_ack_i[g]),
            .mac_tx_rq_o    (mac_tx_rq_o[g]),
            .mac_tx_data_o  (mac_tx_data_o[g]),
            .mac_tx_valid_o (mac_tx_valid_o[g]),
            .mac_tx_sof_o   (mac_tx_sof_o[g]),
            .mac_tx_eof_o   (mac_tx_eof_o[g]),
            .mac_rx_data_i  (mac_rx_data_i[g]),
            .mac_rx_den_i   (mac_rx_den_i[g]),
            .mac_rx_sof_i   (mac_rx_sof_i[g]),
            .mac_rx_eof_i   (mac_rx_eof_i[g])
        );
    end

    port_collect i_collect (
        .clk125M   (clk125M),
        .rst_n_i   (rst_n_i),
        .eth_num_i (eth_num_i),
        .up        (up_bus),
        .data_o    (lnk_tx_data_o),
        .valid_o   (lnk_tx_valid_o),
        .last_o    (lnk_tx_last_o)
    );

endmodule

`default_nettype wire

/* source/eth_bridge_pkg.sv */
/* ethernet bridge common definitions
   port count, rx header size, tx buffer depth and the stream types */
`default_nettype none

package eth_bridge_pkg;

    //----------------------------------------------------------------------
    // sizes
    //----------------------------------------------------------------------
    localparam int ETH_COUNT    = 4;   // ethernet ports on the board
    localparam int RX_HDR_BYTES = 12;  // leading mac rx bytes dropped per frame
    localparam int TX_BUF_DEPTH = 64;  // tx frame buffer, bytes

    //----------------------------------------------------------------------
    // vector types
    //----------------------------------------------------------------------
    typedef logic [7:0]           byte_t;       // stream byte
    typedef logic [1:0]           port_idx_t;   // port number
    typedef logic [ETH_COUNT-1:0] port_mask_t;  // one bit per port

    // tx buffer addressing, pointer wraps at TX_BUF_DEPTH
    typedef logic [5:0]           buf_ptr_t;
    typedef logic [6:0]           buf_cnt_t;    // 0 .. TX_BUF_DEPTH

    // header counter, runs up to RX_HDR_BYTES + 1
    typedef logic [3:0]           hdr_cnt_t;

    // mac tx sequencer
    typedef enum logic [1:0] {
        TX_IDLE,  // nothing to send
        TX_REQ,   // frame buffered, request up, waiting for ack
        TX_SEND   // streaming the frame to the mac
    } tx_state_t;

endpackage

`default_nettype wire

/* source/eth_port.sv */
/* ethernet port bridge
   buffers downlink frames and hands them to the mac by request/ack,
   strips the fixed header off every mac rx frame */
`timescale 1ns/10ps
`default_nettype none

module eth_port (
    input  logic                  clk125M,
    input  logic                  rst_n_i,
    input  logic                  port_en_i,     // module_en & link_up & mac link
    port_bus_if.dst               dn,            // from dispatcher
    port_bus_if.src               up,            // to collector
    // mac tx
    input  logic                  mac_tx_ack_i,
    output logic                  mac_tx_rq_o,
    output eth_bridge_pkg::byte_t mac_tx_data_o,
    output logic                  mac_tx_valid_o,
    output logic                  mac_tx_sof_o,
    output logic                  mac_tx_eof_o,
    // mac rx
    input  eth_bridge_pkg::byte_t mac_rx_data_i,
    input  logic                  mac_rx_den_i,
    input  logic                  mac_rx_sof_i,
    input  logic                  mac_rx_eof_i
);
    import eth_bridge_pkg::*;

    //----------------------------------------------------------------------
    // tx frame buffer
    //----------------------------------------------------------------------
    logic [8:0] tx_mem [TX_BUF_DEPTH];  // {eof, byte}
    logic [8:0] rd_word;
    buf_ptr_t   wr_ptr_q;
    buf_ptr_t   rd_ptr_q;
    buf_cnt_t   fill_q;                 // bytes held
    buf_cnt_t   frm_cnt_q;              // complete frames held
    logic       wr_act_q;               // downlink frame being written
    logic       wr_en;
    logic       rd_en;
    logic       wr_eof;
    logic       rd_eof;
    logic       flush;
    logic       frm_ready;
    tx_state_t  state_q;
    logic       send_q;                 // rd_en one cycle back

    // disabled port drops everything, except a frame already on its way out
    assign flush = !port_en_i && (state_q != TX_SEND);

    // accept only from a sof on, so a frame cut by the enable never lands half
    assign wr_en = dn.valid && port_en_i && (dn.sof || wr_act_q)
                   && (fill_q != buf_cnt_t'(TX_BUF_DEPTH));
    assign wr_eof = wr_en && dn.eof;

    assign rd_en   = (state_q == TX_SEND);
    assign rd_word = tx_mem[rd_ptr_q];      // async read, small buffer
    assign rd_eof  = rd_en && rd_word[8];

    // eof written this cycle counts already, request one cycle later
    assign frm_ready = (frm_cnt_q != '0) || wr_eof;

    always_ff @(posedge clk125M) begin
        if (wr_en) begin
            tx_mem[wr_ptr_q] <= {dn.eof, dn.data};
        end
    end

    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            fill_q    <= '0;
            frm_cnt_q <= '0;
        end else if (flush) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            fill_q    <= '0;
            frm_cnt_q <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + buf_ptr_t'(1);
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + buf_ptr_t'(1);
            end
            fill_q    <= fill_q + buf_cnt_t'(wr_en) - buf_cnt_t'(rd_en);
            frm_cnt_q <= frm_cnt_q + buf_cnt_t'(wr_eof) - buf_cnt_t'(rd_eof);
        end
    end

    // write-side frame tracking
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_act_q <= 1'b0;
        end else if (!port_en_i) begin
            wr_act_q <= 1'b0;
        end else if (wr_en) begin
            wr_act_q <= !dn.eof;
        end
    end

    //----------------------------------------------------------------------
    // mac tx sequencer
    //----------------------------------------------------------------------
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= TX_IDLE;
            send_q  <= 1'b0;
        end else begin
            send_q <= rd_en;
            case (state_q)
                TX_IDLE: begin
                    if (port_en_i && frm_ready) begin
                        state_q <= TX_REQ;
                    end
                end
                TX_REQ: begin
                    if (!port_en_i) begin
                        state_q <= TX_IDLE;  // buffer gets flushed
                    end else if (mac_tx_ack_i) begin
                        state_q <= TX_SEND;  // stream from next cycle
                    end
                end
                TX_SEND: begin
                    if (rd_word[8]) begin
                        state_q <= TX_IDLE;  // rq drops after the eof byte
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    assign mac_tx_rq_o    = (state_q != TX_IDLE);  // held through the whole send
    assign mac_tx_valid_o = rd_en;
    assign mac_tx_data_o  = rd_word[7:0];
    assign mac_tx_sof_o   = rd_en && !send_q;      // first send cycle
    assign mac_tx_eof_o   = rd_eof;

    //----------------------------------------------------------------------
    // rx header strip
    //----------------------------------------------------------------------
    hdr_cnt_t hdr_cnt_q;  // 0 waits for sof, then counts bytes seen
    logic     rx_keep;

    // bytes from index RX_HDR_BYTES on pass
    assign rx_keep = mac_rx_den_i && !mac_rx_sof_i && port_en_i
                     && (hdr_cnt_q >= hdr_cnt_t'(RX_HDR_BYTES));

    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hdr_cnt_q <= '0;
        end else if (!port_en_i) begin
            hdr_cnt_q <= '0;  // resync on the next sof
        end else if (mac_rx_den_i) begin
            if (mac_rx_eof_i) begin
                hdr_cnt_q <= '0;
            end else if (mac_rx_sof_i) begin
                hdr_cnt_q <= hdr_cnt_t'(1);
            end else if (hdr_cnt_q != '0 && hdr_cnt_q <= hdr_cnt_t'(RX_HDR_BYTES)) begin
                hdr_cnt_q <= hdr_cnt_q + hdr_cnt_t'(1);  // parks at RX_HDR_BYTES + 1
            end
        end
    end

    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            up.valid <= 1'b0;
            up.sof   <= 1'b0;
            up.eof   <= 1'b0;
        end else begin
            up.valid <= rx_keep;
            up.sof   <= rx_keep && (hdr_cnt_q == hdr_cnt_t'(RX_HDR_BYTES)); // first kept
            up.eof   <= rx_keep && mac_rx_eof_i;
        end
    end

    always_ff @(posedge clk125M) begin
        up.data <= mac_rx_data_i;
    end

endmodule

`default_nettype wire

/* source/port_bus_if.sv */
/* byte stream link between dispatcher, ports and collector
   one byte per valid cycle, sof/eof qualified by valid, no stall */
`timescale 1ns/10ps
`default_nettype none

interface port_bus_if;
    import eth_bridge_pkg::*;

    byte_t data;   // payload byte
    logic  valid;  // byte present this cycle
    logic  sof;    // first byte of a frame
    logic  eof;    // last byte of a frame

    // producer side
    modport src (
        output data,
        output valid,
        output sof,
        output eof
    );

    // consumer side
    modport dst (
        input  data,
        input  valid,
        input  sof,
        input  eof
    );

endinterface

`default_nettype wire

/* source/port_collect.sv */
/* uplink collector
   forwards whole rx frames of the selected port, switches only between frames */
`timescale 1ns/10ps
`default_nettype none

module port_collect (
    input  logic                      clk125M,
    input  logic                      rst_n_i,
    input  eth_bridge_pkg::port_idx_t eth_num_i,
    port_bus_if.dst                   up [eth_bridge_pkg::ETH_COUNT],
    output eth_bridge_pkg::byte_t     data_o,
    output logic                      valid_o,
    output logic                      last_o
);
    import eth_bridge_pkg::*;

    byte_t      up_data [ETH_COUNT];  // port streams flattened for the mux
    port_mask_t up_valid;
    port_mask_t up_sof;
    port_mask_t up_eof;
    port_idx_t  sel_q;                // port now on the uplink
    logic       busy_q;               // selected frame still open
    logic       busy_d;
    logic       fwd;                  // byte goes to the uplink this cycle

    for (genvar g = 0; g < ETH_COUNT; g++) begin : g_port
        assign up_data[g]  = up[g].data;
        assign up_valid[g] = up[g].valid;
        assign up_sof[g]   = up[g].sof;
        assign up_eof[g]   = up[g].eof;
    end

    // a frame has to start with sof, a tail caught mid-way is dropped
    assign fwd = up_valid[sel_q] && (up_sof[sel_q] || busy_q);

    always_comb begin
        busy_d = busy_q;
        if (fwd) begin
            busy_d = !up_eof[sel_q];
        end
    end

    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel_q   <= '0;
            busy_q  <= 1'b0;
            valid_o <= 1'b0;
            last_o  <= 1'b0;
        end else begin
            busy_q  <= busy_d;
            valid_o <= fwd;
            last_o  <= fwd && up_eof[sel_q];  // eof becomes last
            if (!busy_d) begin
                sel_q <= eth_num_i;           // new selection only between frames
            end
        end
    end

    // payload
    always_ff @(posedge clk125M) begin
        if (fwd) begin
            data_o <= up_data[sel_q];
        end
    end

endmodule

`default_nettype wire

/* source/port_dispatch.sv */
/* downlink dispatcher
   steers each serial-link frame to the port picked on its first byte */
`timescale 1ns/10ps
`default_nettype none

module port_dispatch (
    input  logic                      clk125M,
    input  logic                      rst_n_i,
    input  eth_bridge_pkg::byte_t     data_i,
    input  logic                      valid_i,
    input  logic                      last_i,
    input  eth_bridge_pkg::port_idx_t eth_num_i,
    port_bus_if.src                   dn [eth_bridge_pkg::ETH_COUNT]
);
    import eth_bridge_pkg::*;

    logic       in_frame_q;  // inside a frame, past its first byte
    port_idx_t  tgt_q;       // port latched on the first byte
    port_idx_t  tgt;         // port for the byte on the input now
    byte_t      data_q;
    port_mask_t valid_q;     // one-hot, only the target port sees valid
    logic       sof_q;
    logic       eof_q;

    // first byte takes eth_num_i, the rest of the frame stays put
    assign tgt = in_frame_q ? tgt_q : eth_num_i;

    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_frame_q <= 1'b0;
            tgt_q      <= '0;
            valid_q    <= '0;
            sof_q      <= 1'b0;
            eof_q      <= 1'b0;
        end else begin
            valid_q <= '0;
            sof_q   <= 1'b0;
            eof_q   <= 1'b0;
            if (valid_i) begin
                valid_q    <= port_mask_t'(1) << tgt;
                sof_q      <= !in_frame_q;  // no frame open, so this one starts it
                eof_q      <= last_i;
                tgt_q      <= tgt;
                in_frame_q <= !last_i;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk125M) begin
        if (valid_i) begin
            data_q <= data_i;
        end
    end

    // same byte fanned out, valid decides who takes it
    for (genvar g = 0; g < ETH_COUNT; g++) begin : g_port
        assign dn[g].data  = data_q;
        assign dn[g].valid = valid_q[g];
        assign dn[g].sof   = sof_q;
        assign dn[g].eof   = eof_q;
    end

endmodule

`default_nettype wire
